//--- dbg_ring_demux.sv
module dbg_ring_demux #(
  parameter logic [dbg_ring_pkg::ID_W-1:0] ROUTER_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,

  input  dbg_ring_pkg::dbg_flit_t ring_in_flit,
  input  logic                   ring_in_valid,
  output logic                   ring_in_ready,

  output dbg_ring_pkg::dbg_flit_t local_out_flit,
  output logic                   local_out_valid,
  input  logic                   local_out_ready,

  output dbg_ring_pkg::dbg_flit_t fwd_flit,
  output logic                   fwd_valid,
  input  logic                   fwd_ready
);

  ////////////////////////////////////////////////////////////
  // Wormhole state
  ////////////////////////////////////////////////////////////

  // Packet in flight, header already passed
  logic in_flight;
  // Target of the packet in flight, 1 = local port
  logic tgt_local;

  // Current steering decision
  logic sel_local;
  // Header match against own id
  logic hdr_local;
  // Handshake on the ring input
  logic xfer;

  // Only meaningful while no packet is in flight
  assign hdr_local = (ring_in_flit.word.hdr.dest_id == ROUTER_ID);

  // Header decides, body flits follow the stored target
  assign sel_local = in_flight ? tgt_local : hdr_local;

  ////////////////////////////////////////////////////////////
  // Steering
  ////////////////////////////////////////////////////////////

  // Flit goes to both sides unchanged
  assign local_out_flit = ring_in_flit;
  assign fwd_flit       = ring_in_flit;

  // Only the chosen side sees valid
  assign local_out_valid = ring_in_valid & sel_local;
  assign fwd_valid       = ring_in_valid & ~sel_local;

  // Stall upstream with whichever side is selected
  assign ring_in_ready = sel_local ? local_out_ready : fwd_ready;

  assign xfer = ring_in_valid & ring_in_ready;

  // Load on a multi flit header, clear on last
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
      tgt_local <= 1'b0;
    end else if (xfer) begin
      if (ring_in_flit.last) begin
        in_flight <= 1'b0;
        tgt_local <= 1'b0;
      end else if (!in_flight) begin
        in_flight <= 1'b1;
        tgt_local <= hdr_local;
      end
    end
  end

endmodule

//--- dbg_ring_fifo.sv
module dbg_ring_fifo (
  input  logic                   clk,
  input  logic                   rst,

  input  dbg_ring_pkg::dbg_flit_t in_flit,
  input  logic                   in_valid,
  output logic                   in_ready,

  output dbg_ring_pkg::dbg_flit_t out_flit,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import dbg_ring_pkg::*;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Flit ring buffer, payload only
  dbg_flit_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Flits held
  logic [CNT_W-1:0] count;

  logic do_wr;
  logic do_rd;

  // Full blocks the writer, so no read+write when full
  assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);

  // Head entry straight from the array, no input path
  assign out_flit = mem[rd_ptr];

  assign do_wr = in_valid & in_ready;
  assign do_rd = out_valid & out_ready;

  // Write side
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at depth
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Net change, both at once leaves count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- dbg_ring_mux_rr.sv
module dbg_ring_mux_rr (
  input  logic                   clk,
  input  logic                   rst,

  input  dbg_ring_pkg::dbg_flit_t in0_flit,
  input  logic                   in0_valid,
  output logic                   in0_ready,

  input  dbg_ring_pkg::dbg_flit_t in1_flit,
  input  logic                   in1_valid,
  output logic                   in1_ready,

  output dbg_ring_pkg::dbg_flit_t out_flit,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import dbg_ring_pkg::*;

  ////////////////////////////////////////////////////////////
  // Arbiter state
  ////////////////////////////////////////////////////////////

  logic [1:0] state;
  logic [1:0] nxt_state;

  // Input currently offered, 1 = local
  logic sel1;
  // Output handshake
  logic xfer;
  // Worm locked, from state encoding
  logic worm;

  assign worm = state[1];

  // Pick the input for this cycle
  always_comb begin
    case (state)
      // Preferred first, other one if preferred is empty
      ARB_IDLE0: sel1 = ~in0_valid & in1_valid;
      ARB_IDLE1: sel1 = in1_valid | ~in0_valid;
      // Locked input only, each with its own data and ready
      ARB_WORM0: sel1 = 1'b0;
      default:   sel1 = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  assign out_flit  = sel1 ? in1_flit  : in0_flit;
  assign out_valid = sel1 ? in1_valid : in0_valid;

  // Ready back only to the selected input
  assign in0_ready = ~sel1 & out_ready;
  assign in1_ready = sel1 & out_ready;

  assign xfer = out_valid & out_ready;

  // Next state
  always_comb begin
    nxt_state = state;
    if (xfer && out_flit.last) begin
      // Packet done, hand priority to the other side
      nxt_state = sel1 ? ARB_IDLE0 : ARB_IDLE1;
    end else if (!worm && out_valid) begin
      // Header gone or stalled, hold this input
      // keeps ring_out stable until the tail is taken
      nxt_state = sel1 ? ARB_WORM1 : ARB_WORM0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ARB_IDLE0;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

//--- dbg_ring_pkg.sv
package dbg_ring_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // One flit word on the ring
  localparam int FLIT_W = 32;
  // Node id width in the header
  localparam int ID_W = 8;

  // Flits per FIFO
  localparam int FIFO_DEPTH = 4;
  // FIFO pointer and occupancy widths
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  ////////////////////////////////////////////////////////////
  // Arbiter states
  ////////////////////////////////////////////////////////////

  // Bit 1 set means a worm is locked, bit 0 names the input
  localparam logic [1:0] ARB_IDLE0 = 2'b00;
  localparam logic [1:0] ARB_IDLE1 = 2'b01;
  localparam logic [1:0] ARB_WORM0 = 2'b10;
  localparam logic [1:0] ARB_WORM1 = 2'b11;

  ////////////////////////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////////////////////////

  // Header view of the first flit, msb first
  typedef struct packed {
    logic [ID_W-1:0] dest_id;
    logic [ID_W-1:0] src_id;
    logic [3:0]      pkt_type;
    logic [11:0]     pkt_tag;
  } dbg_hdr_t;

  // Header flit decodes as hdr, later flits are plain payload
  typedef union packed {
    dbg_hdr_t          hdr;
    logic [FLIT_W-1:0] raw;
  } dbg_word_u;

  // Word plus end of packet marker
  typedef struct packed {
    dbg_word_u word;
    logic      last;
  } dbg_flit_t;

endpackage

//--- dbg_ring_router.f
dbg_ring_pkg.sv
dbg_ring_demux.sv
dbg_ring_fifo.sv
dbg_ring_mux_rr.sv
dbg_ring_router.sv
dbg_ring_router_assertions.sv
dbg_ring_router_tb.sv

//--- dbg_ring_router.sv
module dbg_ring_router #(
  parameter logic [dbg_ring_pkg::ID_W-1:0] ROUTER_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,

  // Upstream ring
  input  dbg_ring_pkg::dbg_flit_t ring_in_flit,
  input  logic                   ring_in_valid,
  output logic                   ring_in_ready,

  // Injection from the local debug module
  input  dbg_ring_pkg::dbg_flit_t local_in_flit,
  input  logic                   local_in_valid,
  output logic                   local_in_ready,

  // Downstream ring
  output dbg_ring_pkg::dbg_flit_t ring_out_flit,
  output logic                   ring_out_valid,
  input  logic                   ring_out_ready,

  // Delivery to the local debug module
  output dbg_ring_pkg::dbg_flit_t local_out_flit,
  output logic                   local_out_valid,
  input  logic                   local_out_ready
);

  import dbg_ring_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  // Demux to forward FIFO
  dbg_flit_t fwd_flit;
  logic      fwd_valid;
  logic      fwd_ready;

  // Forward FIFO to arbiter input 0
  dbg_flit_t fwd_q_flit;
  logic      fwd_q_valid;
  logic      fwd_q_ready;

  // Local FIFO to arbiter input 1
  dbg_flit_t loc_q_flit;
  logic      loc_q_valid;
  logic      loc_q_ready;

  // Split by destination id
  dbg_ring_demux #(
    .ROUTER_ID (ROUTER_ID)
  ) u_demux (
    .clk             (clk),
    .rst             (rst),
    .ring_in_flit    (ring_in_flit),
    .ring_in_valid   (ring_in_valid),
    .ring_in_ready   (ring_in_ready),
    .local_out_flit  (local_out_flit),
    .local_out_valid (local_out_valid),
    .local_out_ready (local_out_ready),
    .fwd_flit        (fwd_flit),
    .fwd_valid       (fwd_valid),
    .fwd_ready       (fwd_ready)
  );

  // Pass-through traffic buffer
  dbg_ring_fifo u_fwd_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (fwd_flit),
    .in_valid  (fwd_valid),
    .in_ready  (fwd_ready),
    .out_flit  (fwd_q_flit),
    .out_valid (fwd_q_valid),
    .out_ready (fwd_q_ready)
  );

  // Injected traffic buffer
  dbg_ring_fifo u_local_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (local_in_flit),
    .in_valid  (local_in_valid),
    .in_ready  (local_in_ready),
    .out_flit  (loc_q_flit),
    .out_valid (loc_q_valid),
    .out_ready (loc_q_ready)
  );

  ////////////////////////////////////////////////////////////
  // Merge onto the ring
  ////////////////////////////////////////////////////////////

  dbg_ring_mux_rr u_mux_rr (
    .clk       (clk),
    .rst       (rst),
    .in0_flit  (fwd_q_flit),
    .in0_valid (fwd_q_valid),
    .in0_ready (fwd_q_ready),
    .in1_flit  (loc_q_flit),
    .in1_valid (loc_q_valid),
    .in1_ready (loc_q_ready),
    .out_flit  (ring_out_flit),
    .out_valid (ring_out_valid),
    .out_ready (ring_out_ready)
  );

endmodule

//--- dbg_ring_router_assertions.sv
module dbg_ring_router_assertions #(
  parameter logic [dbg_ring_pkg::ID_W-1:0] ROUTER_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  dbg_ring_pkg::dbg_flit_t ring_out_flit,
  input  logic                    ring_out_valid,
  input  logic                    ring_out_ready,
  input  dbg_ring_pkg::dbg_flit_t local_out_flit,
  input  logic                    local_out_valid,
  input  logic                    local_out_ready,
  input  logic                    fwd_q_valid,
  input  logic                    loc_q_valid
);

  import dbg_ring_pkg::*;

  // Position inside the packet on one output
  typedef struct packed {
    logic            in_pkt;
    logic [ID_W-1:0] src;
  } pkt_trk_t;

  pkt_trk_t out_trk;
  pkt_trk_t loc_trk;
  // Header on ring_out already offered once and arbitrated
  logic hdr_wait;
  // A packet has left on ring_out since reset
  logic have_prev;
  // Failed checks so far
  int fail_cnt = 0;

  task automatic note_fail(input string msg);
    fail_cnt++;
    $error("%s", msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Packet tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_trk   <= '0;
      loc_trk   <= '0;
      hdr_wait  <= 1'b0;
      have_prev <= 1'b0;
    end else begin
      if (ring_out_valid && ring_out_ready) begin
        // Header gives the source for the rest of the worm
        if (!out_trk.in_pkt) begin
          out_trk.src <= ring_out_flit.word.hdr.src_id;
          have_prev   <= 1'b1;
        end
        out_trk.in_pkt <= ~ring_out_flit.last;
        hdr_wait       <= 1'b0;
      end else if (ring_out_valid && !out_trk.in_pkt) begin
        hdr_wait <= 1'b1;
      end
      if (local_out_valid && local_out_ready) begin
        if (!loc_trk.in_pkt) begin
          loc_trk.src <= local_out_flit.word.hdr.src_id;
        end
        loc_trk.in_pkt <= ~local_out_flit.last;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Empty FIFOs out of reset
  a_rst_idle: assert property (@(posedge clk) rst |=> !ring_out_valid)
    else note_fail("ring_out_valid high right after reset");

  // Own id goes local and never back onto the ring
  a_local_route: assert property (@(posedge clk) disable iff (rst)
    local_out_valid && !loc_trk.in_pkt |-> local_out_flit.word.hdr.dest_id == ROUTER_ID)
    else note_fail("local_out header is not addressed to this node");
  a_out_route: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && !out_trk.in_pkt && ring_out_flit.word.hdr.src_id != ROUTER_ID
    |-> ring_out_flit.word.hdr.dest_id != ROUTER_ID)
    else note_fail("packet for this node forwarded on ring_out");

  // Body flits carry the source of their header so no interleaving
  a_out_body: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && out_trk.in_pkt |-> ring_out_flit.word.raw[FLIT_W-1 -: ID_W] == out_trk.src)
    else note_fail("ring_out body flit from another packet");
  a_local_body: assert property (@(posedge clk) disable iff (rst)
    local_out_valid && loc_trk.in_pkt
    |-> local_out_flit.word.raw[FLIT_W-1 -: ID_W] == loc_trk.src)
    else note_fail("local_out body flit from another packet");

  // Round robin when both sides wait
  a_fair: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && !out_trk.in_pkt && !hdr_wait && have_prev && fwd_q_valid && loc_q_valid
    |-> ring_out_flit.word.hdr.src_id != out_trk.src)
    else note_fail("arbiter granted the same source twice while both inputs waited");

  // Stalled outputs hold
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && !ring_out_ready |=> ring_out_valid && $stable(ring_out_flit))
    else note_fail("ring_out dropped or changed while stalled");
  a_local_hold: assert property (@(posedge clk) disable iff (rst)
    local_out_valid && !local_out_ready |=> local_out_valid && $stable(local_out_flit))
    else note_fail("local_out dropped or changed while stalled");

endmodule

bind dbg_ring_router dbg_ring_router_assertions #(.ROUTER_ID(ROUTER_ID)) u_assertions (.*);

//--- dbg_ring_router_tb.sv
module dbg_ring_router_tb;

  import dbg_ring_pkg::*;

  localparam logic [ID_W-1:0] OWN_ID   = 8'h05;
  localparam logic [ID_W-1:0] RING_SRC = 8'h01;
  localparam int              N_TESTS  = 5;

  logic      clk;
  logic      rst;
  dbg_flit_t ring_in_flit;
  logic      ring_in_valid;
  logic      ring_in_ready;
  dbg_flit_t local_in_flit;
  logic      local_in_valid;
  logic      local_in_ready;
  dbg_flit_t ring_out_flit;
  logic      ring_out_valid;
  logic      ring_out_ready;
  dbg_flit_t local_out_flit;
  logic      local_out_valid;
  logic      local_out_ready;

  int seed = 68;
  // Output ready modes, 0 always, 1 random, 2 held low
  int out_mode = 0;
  int loc_mode = 0;
  // Flits per path, 0 ring to local, 1 ring to ring, 2 local to ring
  int sent [3] = '{0, 0, 0};
  int got [3] = '{0, 0, 0};
  int base_sent [3];
  int base_got [3];
  int base_fail;
  string path_sig [3] = '{"local_out_flit", "ring_out_flit fwd", "ring_out_flit inj"};
  // Source of the worm now on ring_out
  logic [ID_W-1:0] mon_src = '0;
  logic            mon_in_pkt = 1'b0;
  int n_pass = 0;
  int n_fail = 0;

  dbg_ring_router #(.ROUTER_ID(OWN_ID)) i_dbg_ring_router (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (N_TESTS * 2000) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", N_TESTS * 2000);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic pick_ready(input int mode);
    if (mode == 2) begin
      return 1'b0;
    end
    if (mode == 1) begin
      return ($random(seed) & 3) != 0;
    end
    return 1'b1;
  endfunction

  // Sink back-pressure
  initial begin
    ring_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      ring_out_ready  = pick_ready(out_mode);
      local_out_ready = pick_ready(loc_mode);
    end
  end

  // Transfers happen at the next rising edge, count them here
  always @(negedge clk) begin
    if (!rst && local_out_valid && local_out_ready) begin
      got[0]++;
    end
    if (!rst && ring_out_valid && ring_out_ready) begin
      if (!mon_in_pkt) begin
        mon_src = ring_out_flit.word.hdr.src_id;
      end
      if (mon_src == OWN_ID) begin
        got[2]++;
      end else begin
        got[1]++;
      end
      mon_in_pkt = ~ring_out_flit.last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Packet drivers
  ////////////////////////////////////////////////////////////

  // Entered and left 10 units after a rising edge
  task automatic send_pkt(input logic on_local, input logic [ID_W-1:0] dest);
    dbg_flit_t       f;
    int              len;
    int              i;
    int              path;
    logic [ID_W-1:0] src;
    len  = 1 + ($random(seed) & 3);
    src  = on_local ? OWN_ID : RING_SRC;
    path = on_local ? 2 : ((dest == OWN_ID) ? 0 : 1);
    for (i = 0; i < len; i++) begin
      if (i == 0) begin
        f.word.hdr.dest_id  = dest;
        f.word.hdr.src_id   = src;
        f.word.hdr.pkt_type = 4'h1;
        f.word.hdr.pkt_tag  = 12'($random(seed));
      end else begin
        // Source in the top byte marks the worm
        f.word.raw = {src, 24'($random(seed))};
      end
      f.last = (i == len - 1);
      if (on_local) begin
        local_in_flit  = f;
        local_in_valid = 1'b1;
        @(negedge clk);
        while (!local_in_ready) @(negedge clk);
      end else begin
        ring_in_flit  = f;
        ring_in_valid = 1'b1;
        @(negedge clk);
        while (!ring_in_ready) @(negedge clk);
      end
      @(posedge clk);
      #10;
      sent[path]++;
    end
    local_in_valid = on_local ? 1'b0 : local_in_valid;
    ring_in_valid  = on_local ? ring_in_valid : 1'b0;
  endtask

  // Half of the ring packets go to this node when to_own is set
  task automatic send_pkts(input logic on_local, input int n, input logic to_own);
    int              k;
    logic [ID_W-1:0] dest;
    for (k = 0; k < n; k++) begin
      dest = 8'h10 + 8'($random(seed) & 15);
      if (!on_local && to_own && (($random(seed) & 1) != 0)) begin
        dest = OWN_ID;
      end
      send_pkt(on_local, dest);
    end
  endtask

  function automatic logic drained();
    int p;
    for (p = 0; p < 3; p++) begin
      if (got[p] - base_got[p] != sent[p] - base_sent[p]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic start_test();
    base_sent = sent;
    base_got  = got;
    base_fail = i_dbg_ring_router.u_assertions.fail_cnt;
  endtask

  // Wait for the paths to drain, then compare per path
  task automatic finish_test(input string name);
    int t;
    int p;
    int bad;
    t   = 0;
    bad = 0;
    while (!drained() && t < 400) begin
      @(posedge clk);
      #10;
      t++;
    end
    for (p = 0; p < 3; p++) begin
      if (got[p] - base_got[p] != sent[p] - base_sent[p]) begin
        $display("ERR %s count exp %h act %h", path_sig[p],
                 sent[p] - base_sent[p], got[p] - base_got[p]);
        bad++;
      end
    end
    if (i_dbg_ring_router.u_assertions.fail_cnt != base_fail) begin
      $display("%s: assertion checks failed during the test", name);
      bad++;
    end
    if (bad == 0) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: failed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst            = 1'b1;
    ring_in_flit   = '0;
    ring_in_valid  = 1'b0;
    local_in_flit  = '0;
    local_in_valid = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    start_test();
    repeat (20) @(posedge clk);
    #10;
    finish_test("reset_idle");

    start_test();
    send_pkts(1'b0, 16, 1'b1);
    finish_test("routing");

    start_test();
    fork
      send_pkts(1'b0, 12, 1'b0);
      send_pkts(1'b1, 12, 1'b0);
    join
    finish_test("merge");

    // Fill both FIFOs behind a stalled ring_out
    start_test();
    out_mode = 2;
    fork
      send_pkts(1'b0, 6, 1'b0);
      send_pkts(1'b1, 6, 1'b0);
      begin
        repeat (40) @(posedge clk);
        out_mode = 0;
      end
    join
    finish_test("fairness");

    start_test();
    out_mode = 1;
    loc_mode = 1;
    fork
      send_pkts(1'b0, 20, 1'b1);
      send_pkts(1'b1, 20, 1'b0);
    join
    finish_test("back_pressure");

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dbg_ring_router_tb \
  -f dbg_ring_router.f -o dbg_ring_router_sim

# Keep running past failed assertions so the testbench reports them
out=$(./obj_dir/dbg_ring_router_sim +verilator+error+limit+1000 || true)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"
